// ==== dv/decodeTb.sv ====
// Self-checking testbench for the decode stage; compile with sim.f and run decodeTb as the top
`timescale 1ns/1ps
`default_nettype none

module decodeTb;

	import decodePkg::*;

	localparam logic [31:0] SEED = 32'h7289_1f82;

	// Words sent by each test, used to size the watchdog
	localparam int TARGET_WORDS = 55;
	localparam int BRANCH_WORDS = 10;
	localparam int IMM_WORDS = 10;
	localparam int SOURCE_WORDS = 12;
	localparam int STREAM_WORDS = 200;
	localparam int TOTAL_WORDS = TARGET_WORDS + BRANCH_WORDS + IMM_WORDS
		+ SOURCE_WORDS + STREAM_WORDS;

	logic clk;
	logic rst;
	logic inValid;
	logic inReady;
	instruction_t inInstr;
	logic outValid;
	logic outReady;
	decodeRec_t outRec;

	// Expected records in delivery order
	decodeRec_t expQ [$];

	// Prefix as the reference model sees it
	logic modelPfxHeld = 1'b0;
	logic [24:0] modelPfx = '0;

	logic [31:0] stimState = SEED;
	logic stallMode = 1'b0;
	int errCount = 0;
	int checkCount = 0;

	// Opcodes for random picks; the last entry is an unassigned code
	logic [6:0] opTable [0:33];

	decodeStage uut (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.outValid(outValid),
		.outReady(outReady),
		.outRec(outRec)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// ======================================================================
	// Helpers
	// ======================================================================
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Random fields above the given opcode
	function automatic logic [31:0] randWord(input logic [6:0] op);
		stimState = xorshift(stimState);
		return {stimState[31:7], op};
	endfunction

	// Expected record for one non-prefix word and the prefix held before it
	function automatic decodeRec_t refDecode(input logic [31:0] word, input logic pfxHeld,
		input logic [24:0] pfxPayload);
		decodeRec_t rec;
		logic [37:0] wide;
		logic [63:0] shortImm;
		logic [63:0] brImm;
		rec = '0;
		rec.instr = word;
		rec.hasPrefix = pfxHeld;
		// With a prefix the payload sits above the 13 bit field before sign extension
		wide = {pfxPayload, word[31:19]};
		if (pfxHeld)
			shortImm = {{26{wide[37]}}, wide};
		else
			shortImm = {{51{word[31]}}, word[31:19]};
		brImm = {{41{word[31]}}, word[31:9]};
		case (word[6:0])
		OP_R2:
		begin
			if (word[31:25] <= 7'd24)
				rec.rt = word[12:7];
			rec.ra = word[18:13];
			rec.rb = word[24:19];
		end
		OP_SHIFT:
		begin
			rec.rt = word[12:7];
			rec.ra = word[18:13];
			rec.rb = word[24:19];
		end
		OP_FLT2, OP_FLT3:
		begin
			rec.rt = word[12:7];
			rec.rb = word[24:19];
		end
		OP_MOV, OP_CSR:
			rec.rt = word[12:7];
		OP_BSR, OP_JSR:
		begin
			case (word[8:7])
			2'd0: rec.rt = 6'd0;
			2'd1: rec.rt = 6'd57;
			2'd2: rec.rt = 6'd58;
			default: rec.rt = 6'd59;
			endcase
			rec.imm = brImm;
		end
		OP_RTD:
			rec.rt = 6'd62;
		OP_DBRA:
		begin
			rec.rt = 6'd55;
			rec.imm = brImm;
		end
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI, OP_MULUI, OP_DIVUI,
		OP_ANDI, OP_ORI, OP_EORI, OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT,
		OP_LDTU, OP_LDO, OP_LDA, OP_LDX:
		begin
			rec.rt = word[12:7];
			rec.ra = word[18:13];
			rec.imm = shortImm;
		end
		OP_STB, OP_STO:
		begin
			rec.ra = word[18:13];
			rec.rc = word[12:7];
			rec.imm = shortImm;
		end
		default:
			rec.rt = 6'd0;
		endcase
		rec.writesRt = (rec.rt != 6'd0);
		return rec;
	endfunction

	task automatic checkField(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			$display("error %0t %s got %h expected %h", $time, name, got, exp);
			errCount++;
		end
	endtask

	// Offer one word and update the model at the edge that takes it
	task automatic sendWord(input logic [31:0] word);
		@(negedge clk);
		inValid = 1'b1;
		inInstr = word;
		@(posedge clk);
		while (!inReady)
			@(posedge clk);
		if (word[6:0] == OP_PFX)
		begin
			modelPfxHeld = 1'b1;
			modelPfx = word[31:7];
		end
		else
		begin
			expQ.push_back(refDecode(word, modelPfxHeld, modelPfx));
			modelPfxHeld = 1'b0;
		end
	endtask

	// Idle the input, let every expected record drain, then report
	task automatic finishTest(input string name, input int errBefore);
		@(negedge clk);
		inValid = 1'b0;
		while (expQ.size() != 0 || outValid)
			@(negedge clk);
		$display("%s finished with %0d error(s)", name, errCount - errBefore);
	endtask

	// ======================================================================
	// Output side: back-pressure and comparison
	// ======================================================================
	initial
	begin
		logic [31:0] sinkState;
		sinkState = ~SEED;
		outReady = 1'b1;
		forever
		begin
			@(negedge clk);
			sinkState = xorshift(sinkState);
			// About five cycles in eight accept a record while stalls are on
			outReady = !stallMode || (sinkState[2:0] > 3'd2);
		end
	end

	logic holdActive = 1'b0;
	decodeRec_t heldRec;

	always @(posedge clk)
	begin
		decodeRec_t expRec;
		if (!rst)
		begin
			// A stalled record must still be there and unchanged
			if (holdActive)
			begin
				checkCount++;
				assert (outValid && outRec === heldRec)
				else
				begin
					$display("stalled record was dropped or changed at %0t", $time);
					errCount++;
				end
			end
			if (outValid && outReady)
			begin
				checkCount++;
				assert (expQ.size() != 0)
				else
				begin
					$display("record delivered with none expected at %0t", $time);
					errCount++;
				end
				if (expQ.size() != 0)
				begin
					expRec = expQ.pop_front();
					checkField("outRec.instr", outRec.instr, expRec.instr);
					checkField("outRec.rt", outRec.rt, expRec.rt);
					checkField("outRec.ra", outRec.ra, expRec.ra);
					checkField("outRec.rb", outRec.rb, expRec.rb);
					checkField("outRec.rc", outRec.rc, expRec.rc);
					checkField("outRec.writesRt", outRec.writesRt, expRec.writesRt);
					checkField("outRec.imm", outRec.imm, expRec.imm);
					checkField("outRec.hasPrefix", outRec.hasPrefix, expRec.hasPrefix);
				end
			end
		end
		holdActive = !rst && outValid && !outReady;
		heldRec = outRec;
	end

	// The run may take at most twenty cycles per word
	initial
	begin
		repeat (TOTAL_WORDS * 20)
			@(posedge clk);
		$display("timeout: decode stage stopped delivering records");
		$display("test failed");
		$finish;
	end

	// ======================================================================
	// Tests
	// ======================================================================
	initial
	begin
		int errBefore;
		int idx;
		logic [31:0] word;
		rst = 1'b1;
		inValid = 1'b0;
		inInstr = '0;
		opTable = '{OP_R2, OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI,
			OP_MULUI, OP_DIVUI, OP_FLT2, OP_FLT3, OP_ANDI, OP_ORI, OP_EORI, OP_SHIFT,
			OP_CSR, OP_MOV, OP_BSR, OP_JSR, OP_RTD, OP_DBRA, OP_LDB, OP_LDBU, OP_LDW,
			OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA, OP_LDX, OP_STB, OP_STO, OP_PFX,
			7'd1};
		repeat (5)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Idle state right after reset
		errBefore = errCount;
		@(negedge clk);
		checkField("outValid", outValid, 1'b0);
		checkField("inReady", inReady, 1'b1);
		$display("reset state finished with %0d error(s)", errCount - errBefore);

		// Every R2 function, three unassigned ones, then the other forms
		errBefore = errCount;
		for (idx = 0; idx < 28; idx++)
		begin
			word = randWord(OP_R2);
			if (idx < 25)
				word[31:25] = idx[6:0];
			else
				word[31:25] = 7'd25 + 7'((idx - 25) * 51);
			sendWord(word);
		end
		for (idx = 1; idx <= 16; idx++)
			sendWord(randWord(opTable[idx]));
		for (idx = 21; idx <= 31; idx++)
			sendWord(randWord(opTable[idx]));
		finishTest("target decode", errBefore);

		// Link selects and the fixed targets
		errBefore = errCount;
		for (idx = 0; idx < 8; idx++)
		begin
			word = randWord((idx < 4) ? OP_BSR : OP_JSR);
			word[8:7] = idx[1:0];
			sendWord(word);
		end
		sendWord(randWord(OP_RTD));
		sendWord(randWord(OP_DBRA));
		finishTest("branch targets", errBefore);

		// Sign extension, prefix merge, prefix replacement and a branch after a prefix
		errBefore = errCount;
		sendWord({13'h0123, 6'd5, 6'd9, OP_ADDI});
		sendWord({13'h1f00, 6'd3, 6'd4, OP_ADDI});
		sendWord({25'h1abcdef, OP_PFX});
		sendWord({13'h0042, 6'd7, 6'd8, OP_ADDI});
		sendWord({25'h0001234, OP_PFX});
		sendWord({25'h0765432, OP_PFX});
		sendWord({13'h1fff, 6'd2, 6'd11, OP_LDB});
		sendWord({25'h1000001, OP_PFX});
		sendWord({23'h400010, 2'd1, OP_BSR});
		sendWord({13'h1000, 6'd12, 6'd13, OP_STO});
		finishTest("immediate and prefix", errBefore);

		// Source registers of R2, load and store forms
		errBefore = errCount;
		for (idx = 0; idx < 4; idx++)
		begin
			word = randWord(OP_R2);
			word[31:25] = 7'(idx * 6);
			sendWord(word);
			sendWord(randWord(opTable[21 + 2 * idx]));
			sendWord(randWord(idx[0] ? OP_STO : OP_STB));
		end
		finishTest("source decode", errBefore);

		// Random stream under random back-pressure
		errBefore = errCount;
		@(posedge clk);
		stallMode = 1'b1;
		for (idx = 0; idx < STREAM_WORDS; idx++)
		begin
			stimState = xorshift(stimState);
			sendWord(randWord(opTable[stimState % 34]));
		end
		finishTest("back-pressure stream", errBefore);

		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/decodeControl.sv ====
// Prefix FSM, valid/ready handshake and output record register of the decode stage
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decodeControl (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input decodePkg::instruction_t inInstr,
	input decodePkg::regspec_t tgt,
	input logic writesRt,
	input decodePkg::regspec_t ra,
	input decodePkg::regspec_t rb,
	input decodePkg::regspec_t rc,
	input logic [`VALUE_W-1:0] imm,
	output logic pfxValid,
	output logic [`PFX_W-1:0] pfxBits,
	output logic outValid,
	input logic outReady,
	output decodePkg::decodeRec_t outRec
);

	import decodePkg::*;

	typedef enum logic {ST_PLAIN, ST_PREFIXED} ctrlState_t;

	ctrlState_t state;
	logic [`PFX_W-1:0] pfxReg;
	logic take;
	logic isPfx;
	decodeRec_t nextRec;

	// ======================================================================
	// Handshake
	// ======================================================================

	// Accept whenever the output slot is empty or drains this cycle
	assign inReady = !outValid || outReady;
	assign take = inValid && inReady;
	assign isPfx = (inInstr.any.opcode == OP_PFX);

	assign pfxValid = (state == ST_PREFIXED);
	assign pfxBits = pfxReg;

	// Record of the word on the input, built from the three decoders
	always_comb
	begin
		nextRec.instr = inInstr;
		nextRec.rt = tgt;
		nextRec.ra = ra;
		nextRec.rb = rb;
		nextRec.rc = rc;
		nextRec.writesRt = writesRt;
		nextRec.imm = imm;
		nextRec.hasPrefix = pfxValid;
	end

	// ======================================================================
	// Prefix FSM and output valid
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_PLAIN;
			outValid <= 1'b0;
		end
		else
		begin
			if (outValid && outReady)
				outValid <= 1'b0;
			if (take)
			begin
				// A prefix only loads state and any other word consumes it
				if (isPfx)
					state <= ST_PREFIXED;
				else
				begin
					state <= ST_PLAIN;
					outValid <= 1'b1;
				end
			end
		end
	end

	// Payload registers load on the handshake only
	always_ff @(posedge clk)
	begin
		if (take && isPfx)
			pfxReg <= inInstr.pfx.payload;
		if (take && !isPfx)
			outRec <= nextRec;
	end

	// ======================================================================
	// Assertions
	// ======================================================================

	// A stalled record stays valid and unchanged into the next cycle
	aStallHold: assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> outValid && $stable(outRec))
		else $error("output record changed while stalled");

	// The input is open whenever the output slot is empty
	aReadyIdle: assert property (@(posedge clk) disable iff (rst)
		!outValid |-> inReady)
		else $error("input blocked with empty output slot");

	// A word offered during a stall must not touch the prefix state
	aNoCaptureStall: assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=>
		$stable(state) && (!pfxValid || $stable(pfxReg)))
		else $error("prefix state changed while stalled");

endmodule

`default_nettype wire

// ==== hdl/decodeImmediate.sv ====
// Combinational immediate extraction with sign extension and prefix merge, used by decode top
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decodeImmediate (
	input decodePkg::instruction_t instr,
	input logic pfxValid,
	input logic [`PFX_W-1:0] pfxBits,
	output logic [`VALUE_W-1:0] imm
);

	import decodePkg::*;

	// Short field of the current word
	logic [`IMM_W-1:0] shortField;

	// Prefix payload stacked above the short field
	logic [`PFX_W+`IMM_W-1:0] longField;

	// ======================================================================
	// Field extraction
	// ======================================================================

	// Immediates, load and store displacements all sit in bits 31 to 19
	assign shortField = instr.ri.imm;

	assign longField = {pfxBits, shortField};

	// ======================================================================
	// Extension to the full width
	// ======================================================================
	always_comb
	begin
		case (instr.any.opcode)
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI,
		OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI,
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
		OP_LDO, OP_LDA, OP_LDX, OP_STB, OP_STO:
			// A held prefix turns the short field into a 38 bit value
			if (pfxValid)
				imm = {{(`VALUE_W-`PFX_W-`IMM_W){longField[`PFX_W+`IMM_W-1]}}, longField};
			else
				imm = {{(`VALUE_W-`IMM_W){shortField[`IMM_W-1]}}, shortField};
		// Branch displacements are wide enough already and ignore any prefix
		OP_BSR, OP_JSR, OP_DBRA:
			imm = {{(`VALUE_W-`BR_DISP_W){instr.br.disp[`BR_DISP_W-1]}}, instr.br.disp};
		default:
			imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/decodePkg.sv ====
// Shared decode types: opcode and function codes, instruction views and the decode record
`default_nettype none

package decodePkg;

`include "decode_consts.svh"

	// ======================================================================
	// Major opcodes in bits 6 to 0
	// ======================================================================
	typedef enum logic [6:0] {
		OP_R2    = 7'd2,
		OP_ADDI  = 7'd4,
		OP_SUBFI = 7'd5,
		OP_CMPI  = 7'd6,
		OP_MULI  = 7'd7,
		OP_DIVI  = 7'd8,
		OP_SLTI  = 7'd9,
		OP_MULUI = 7'd10,
		OP_DIVUI = 7'd11,
		OP_FLT2  = 7'd12,
		OP_FLT3  = 7'd13,
		OP_ANDI  = 7'd16,
		OP_ORI   = 7'd17,
		OP_EORI  = 7'd18,
		OP_SHIFT = 7'd20,
		OP_CSR   = 7'd21,
		OP_MOV   = 7'd22,
		OP_BSR   = 7'd32,
		OP_JSR   = 7'd33,
		OP_RTD   = 7'd34,
		OP_DBRA  = 7'd35,
		OP_LDB   = 7'd64,
		OP_LDBU  = 7'd65,
		OP_LDW   = 7'd66,
		OP_LDWU  = 7'd67,
		OP_LDT   = 7'd68,
		OP_LDTU  = 7'd69,
		OP_LDO   = 7'd70,
		OP_LDA   = 7'd71,
		OP_LDX   = 7'd72,
		OP_STB   = 7'd80,
		OP_STO   = 7'd83,
		OP_PFX   = 7'd120
	} opcode_t;

	// Register to register functions in bits 31 to 25 of an R2 word
	// Codes from 25 upward are unassigned and decode as no operation
	typedef enum logic [6:0] {
		FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB,
		FN_MULU, FN_DIVU, FN_MULH, FN_MOD, FN_MULUH,
		FN_MODU, FN_AND, FN_OR, FN_EOR, FN_ANDC,
		FN_NAND, FN_NOR, FN_ENOR, FN_ORC, FN_SEQ,
		FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU
	} func_t;

	typedef logic [`REG_W-1:0] regspec_t;

	// ======================================================================
	// Instruction word views
	// ======================================================================

	// Every view keeps the opcode in the low seven bits
	typedef struct packed {
		logic [`PFX_W-1:0] body;
		opcode_t opcode;
	} anyView_t;

	typedef struct packed {
		func_t func;
		regspec_t Rb;
		regspec_t Ra;
		regspec_t Rt;
		opcode_t opcode;
	} r2View_t;

	typedef struct packed {
		logic [`IMM_W-1:0] imm;
		regspec_t Ra;
		regspec_t Rt;
		opcode_t opcode;
	} riView_t;

	// Loads use the same layout with a displacement in place of the immediate
	typedef struct packed {
		logic [`IMM_W-1:0] disp;
		regspec_t Ra;
		regspec_t Rt;
		opcode_t opcode;
	} lsView_t;

	// Stores carry the data register where other forms have the target
	typedef struct packed {
		logic [`IMM_W-1:0] disp;
		regspec_t Ra;
		regspec_t Rs;
		opcode_t opcode;
	} stView_t;

	typedef struct packed {
		logic [`BR_DISP_W-1:0] disp;
		logic [1:0] lk;
		opcode_t opcode;
	} brView_t;

	typedef struct packed {
		logic [`PFX_W-1:0] payload;
		opcode_t opcode;
	} pfxView_t;

	typedef union packed {
		anyView_t any;
		r2View_t r2;
		riView_t ri;
		lsView_t ls;
		stView_t st;
		brView_t br;
		pfxView_t pfx;
	} instruction_t;

	// One decoded instruction as handed to the next stage
	typedef struct packed {
		logic [`INSTR_W-1:0] instr;
		regspec_t rt;
		regspec_t ra;
		regspec_t rb;
		regspec_t rc;
		logic writesRt;
		logic [`VALUE_W-1:0] imm;
		logic hasPrefix;
	} decodeRec_t;

endpackage

`default_nettype wire

// ==== hdl/decodeSources.sv ====
// Combinational source register decode, instantiated by the decode stage top
`timescale 1ns/1ps
`default_nettype none

module decodeSources (
	input decodePkg::instruction_t instr,
	output decodePkg::regspec_t ra,
	output decodePkg::regspec_t rb,
	output decodePkg::regspec_t rc
);

	import decodePkg::*;

	// ======================================================================
	// Source selection by opcode
	// ======================================================================
	always_comb
	begin
		ra = '0;
		rb = '0;
		rc = '0;
		case (instr.any.opcode)
		// Register to register forms read both Ra and Rb
		OP_R2, OP_SHIFT:
		begin
			ra = instr.r2.Ra;
			rb = instr.r2.Rb;
		end
		// Float forms only read the second operand field here
		OP_FLT2, OP_FLT3:
			rb = instr.r2.Rb;
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI,
		OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI:
			ra = instr.ri.Ra;
		// Loads read only the base register
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
		OP_LDO, OP_LDA, OP_LDX:
			ra = instr.ls.Ra;
		OP_STB, OP_STO:
		begin
			// The base goes to ra and the data register to rc
			ra = instr.st.Ra;
			rc = instr.st.Rs;
		end
		default:
		begin
			ra = '0;
			rb = '0;
			rc = '0;
		end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
// Top of the register and immediate decode stage, joining the control block and three decoders
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decodeStage (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input decodePkg::instruction_t inInstr,
	output logic outValid,
	input logic outReady,
	output decodePkg::decodeRec_t outRec
);

	import decodePkg::*;

	// Decoder results for the word currently on the input
	regspec_t tgtReg;
	logic tgtWrites;
	regspec_t srcA;
	regspec_t srcB;
	regspec_t srcC;
	logic [`VALUE_W-1:0] immValue;

	// Held prefix as seen by the immediate decoder
	logic pfxValid;
	logic [`PFX_W-1:0] pfxBits;

	// ======================================================================
	// Control and record register
	// ======================================================================
	decodeControl ctrl (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.tgt(tgtReg),
		.writesRt(tgtWrites),
		.ra(srcA),
		.rb(srcB),
		.rc(srcC),
		.imm(immValue),
		.pfxValid(pfxValid),
		.pfxBits(pfxBits),
		.outValid(outValid),
		.outReady(outReady),
		.outRec(outRec)
	);

	// ======================================================================
	// Decoders
	// ======================================================================
	decodeTarget tgtDec (
		.instr(inInstr),
		.rt(tgtReg),
		.writesRt(tgtWrites)
	);

	decodeSources srcDec (
		.instr(inInstr),
		.ra(srcA),
		.rb(srcB),
		.rc(srcC)
	);

	decodeImmediate immDec (
		.instr(inInstr),
		.pfxValid(pfxValid),
		.pfxBits(pfxBits),
		.imm(immValue)
	);

endmodule

`default_nettype wire

// ==== hdl/decodeTarget.sv ====
// Combinational target register and write flag decode, instantiated by the decode stage top
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decodeTarget (
	input decodePkg::instruction_t instr,
	output decodePkg::regspec_t rt,
	output logic writesRt
);

	import decodePkg::*;

	// ======================================================================
	// Target selection by opcode
	// ======================================================================
	always_comb
	begin
		rt = '0;
		case (instr.any.opcode)
		OP_R2:
			// Only assigned functions produce a result
			case (instr.r2.func)
			FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB,
			FN_MULU, FN_DIVU, FN_MULH, FN_MOD, FN_MULUH,
			FN_MODU, FN_AND, FN_OR, FN_EOR, FN_ANDC,
			FN_NAND, FN_NOR, FN_ENOR, FN_ORC, FN_SEQ,
			FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
				rt = instr.r2.Rt;
			default:
				rt = '0;
			endcase
		OP_FLT2, OP_FLT3, OP_SHIFT, OP_MOV:
			rt = instr.r2.Rt;
		OP_BSR, OP_JSR:
			// The link field picks one of three link registers or none
			case (instr.br.lk)
			2'd0: rt = '0;
			2'd1: rt = `LINK0_REG;
			2'd2: rt = `LINK1_REG;
			default: rt = `LINK2_REG;
			endcase
		OP_RTD:
			rt = `RET_REG;
		OP_DBRA:
			rt = `LOOP_REG;
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI,
		OP_MULUI, OP_DIVUI, OP_ANDI, OP_ORI, OP_EORI:
			rt = instr.ri.Rt;
		// CSR access shares the immediate layout
		OP_CSR:
			rt = instr.ri.Rt;
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
		OP_LDO, OP_LDA, OP_LDX:
			rt = instr.ls.Rt;
		// Stores, prefixes and unassigned opcodes leave the target empty
		default:
			rt = '0;
		endcase
	end

	// Register 0 is hardwired so a zero target never counts as a write
	assign writesRt = (rt != '0);

endmodule

`default_nettype wire

// ==== hdl/decode_consts.svh ====
// Width and fixed register number macros for the decode stage, included by the package and RTL
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// ======================================================================
// Word widths
// ======================================================================

// Fetched instruction word
`define INSTR_W 32

// Register specifier covers a 64 entry register file
`define REG_W 6

// Full immediate as delivered in the decode record
`define VALUE_W 64

// Payload carried by a prefix instruction in bits 31 to 7
`define PFX_W 25

// Short immediate and displacement field of the ri, ls and st forms
`define IMM_W 13

// Displacement field of the branch form
`define BR_DISP_W 23

// ======================================================================
// Fixed register numbers
// ======================================================================

// Link registers selected by the two bit link field of BSR and JSR
// Link select 0 means no link is written
`define LINK0_REG 6'd57
`define LINK1_REG 6'd58
`define LINK2_REG 6'd59

// Return writes the adjusted stack pointer
`define RET_REG 6'd62

// Decrement and branch counts down this register
`define LOOP_REG 6'd55

`endif

// ==== sim.f ====
+incdir+hdl
hdl/decodePkg.sv
hdl/decodeTarget.sv
hdl/decodeSources.sv
hdl/decodeImmediate.sv
hdl/decodeControl.sv
hdl/decodeStage.sv
dv/decodeTb.sv
